//--- sources.f
+incdir+include
hw/cfu_pkg.sv
hw/mac_lane.sv
hw/requantizer.sv
hw/cmd_decoder.sv
hw/result_unit.sv
hw/cfu_top.sv
test/tb_cfu.sv

//--- Makefile
VERILATOR = verilator

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module cfu_top -f sources.f

sim:
	$(VERILATOR) --binary --timing --assert -Wno-fatal --top-module tb_cfu -f sources.f
	./obj_dir/Vtb_cfu | tee /dev/stderr | grep -q "Simulation passed"

clean:
	rm -rf obj_dir

//--- include/cfu_vectors.svh
// ********************
// CFU test vectors
// Commands and expected responses, applied in order
// ********************
`ifndef CFU_VECTORS_SVH
`define CFU_VECTORS_SVH

typedef struct packed {
  func_id_t func_id;
  word_t    operand_0;
  word_t    operand_1;
  word_t    expected;
} vector_t;

localparam int NUM_VECTORS = 28;

// Columns: function ID, operand 0, operand 1, expected response
localparam vector_t VECTORS [NUM_VECTORS] = '{
  {10'h000, 32'h1234_5605, 32'h0000_0000, 32'h1234_5605},
  {10'h008, 32'h0403_0201, 32'hFF02_FD01, 32'hFFFF_FFF8},
  {10'h008, 32'h80F0_7FFF, 32'h7F80_03FE, 32'hFFFF_C9FF},
  // Tail dot with counts 0 to 3, then an oversized count
  {10'h010, 32'h0403_0201, 32'h0002_FD01, 32'h0000_0000},
  {10'h010, 32'h0403_0201, 32'h0102_FD01, 32'h0000_0006},
  {10'h010, 32'h0403_0201, 32'h0202_FD01, 32'hFFFF_FFF1},
  {10'h010, 32'h0403_0201, 32'h0302_FD01, 32'h0000_0001},
  {10'h010, 32'h0403_0201, 32'hFF02_FD01, 32'h0000_0001},
  // Negative offset of -10
  {10'h000, 32'h0000_00F6, 32'h0000_0000, 32'h0000_00F6},
  {10'h008, 32'h0A14_1E28, 32'h0101_0101, 32'h0000_003C},
  // Multiplier 0.5 and shift -2, total shift 33 with rounding
  {10'h001, 32'h4000_0000, 32'h0000_0000, 32'h4000_0000},
  {10'h009, 32'h0000_00FE, 32'h0000_0000, 32'h0000_00FE},
  {10'h011, 32'h0000_03EC, 32'h0000_0000, 32'h0000_007E},
  {10'h011, 32'hFFFF_FC14, 32'h0000_0000, 32'hFFFF_FF83},
  // Shift 34 gives a left shift by 3
  {10'h009, 32'h0000_0022, 32'h0000_0000, 32'h0000_0022},
  {10'h001, 32'h0000_0003, 32'h0000_0000, 32'h0000_0003},
  {10'h011, 32'h0000_0100, 32'h0000_0000, 32'h0000_1800},
  {10'h011, 32'hFFFF_FFFB, 32'h0000_0000, 32'hFFFF_FF88},
  // Accumulator sequence
  {10'h002, 32'hDEAD_BEEF, 32'h0000_0000, 32'h0000_0000},
  {10'h00A, 32'h0A14_1E28, 32'h0101_0101, 32'h0000_003C},
  {10'h00A, 32'h0A14_1E28, 32'hFFFF_0203, 32'h0000_00B4},
  {10'h022, 32'hFFFF_FF38, 32'h0000_0000, 32'hFFFF_FFEC},
  {10'h012, 32'h0000_0000, 32'h0000_0000, 32'hFFFF_FFEC},
  {10'h001, 32'h4000_0000, 32'h0000_0000, 32'h4000_0000},
  {10'h009, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000},
  {10'h01A, 32'h0000_0000, 32'h0000_0000, 32'hFFFF_FFF6},
  // Unknown code echoes, accumulator untouched
  {10'h3FF, 32'hCAFE_F00D, 32'h1111_2222, 32'hCAFE_F00D},
  {10'h012, 32'h0000_0000, 32'h0000_0000, 32'hFFFF_FFF6}
};

`endif

//--- test/tb_cfu.sv
// ********************
// CFU testbench
// Applies the vector table under random response
// back-pressure and checks every response
// ********************
module tb_cfu;
  timeunit 1ns;
  timeprecision 1ps;
  import cfu_pkg::*;

  `include "cfu_vectors.svh"

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 8;

  logic     clk;
  logic     reset;
  logic     cmd_valid;
  logic     cmd_ready;
  func_id_t cmd_function_id;
  word_t    cmd_inputs_0;
  word_t    cmd_inputs_1;
  logic     rsp_valid;
  logic     rsp_ready;
  word_t    rsp_outputs_0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  cfu_top u_cfu_top (
    .cmd_valid       (cmd_valid),
    .cmd_ready       (cmd_ready),
    .cmd_function_id (cmd_function_id),
    .cmd_inputs_0    (cmd_inputs_0),
    .cmd_inputs_1    (cmd_inputs_1),
    .rsp_valid       (rsp_valid),
    .rsp_ready       (rsp_ready),
    .rsp_outputs_0   (rsp_outputs_0),
    .clk             (clk),
    .reset           (reset)
  );

  task automatic stop_with_error(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1);
  endtask

  // No response pending and ready for the next command
  task automatic check_idle(input string where);
    assert (!rsp_valid) else
      stop_with_error($sformatf("ERR rsp_valid %s: got 0x%0h expected 0x0",
                                where, rsp_valid));
    assert (cmd_ready) else
      stop_with_error($sformatf("ERR cmd_ready %s: got 0x%0h expected 0x1",
                                where, cmd_ready));
  endtask

  // Pending response holds its payload and blocks new commands
  task automatic check_pending(input int idx, input word_t expected);
    assert (rsp_valid) else
      stop_with_error($sformatf("ERR rsp_valid vector %0d: got 0x%0h expected 0x1",
                                idx, rsp_valid));
    assert (rsp_outputs_0 === expected) else
      stop_with_error($sformatf("ERR rsp_outputs_0 vector %0d: got 0x%08h expected 0x%08h",
                                idx, rsp_outputs_0, expected));
    assert (!cmd_ready) else
      stop_with_error($sformatf("ERR cmd_ready vector %0d: got 0x%0h expected 0x0",
                                idx, cmd_ready));
  endtask

  task automatic run_vector(input int idx);
    vector_t vec;
    int      stall;
    vec   = VECTORS[idx];
    stall = $urandom_range(3, 0);
    @(negedge clk);
    cmd_valid       = 1'b1;
    cmd_function_id = vec.func_id;
    cmd_inputs_0    = vec.operand_0;
    cmd_inputs_1    = vec.operand_1;
    while (!cmd_ready) begin
      @(negedge clk);
    end
    // Accepted on the rising edge just passed
    @(negedge clk);
    cmd_valid       = 1'b0;
    cmd_function_id = 10'($urandom());
    cmd_inputs_0    = $urandom();
    cmd_inputs_1    = $urandom();
    assert (rsp_valid) else
      stop_with_error($sformatf("ERR rsp_valid vector %0d: got 0x%0h expected 0x1 after accept",
                                idx, rsp_valid));
    for (int c = 0; c < stall; c++) begin
      check_pending(idx, vec.expected);
      @(negedge clk);
    end
    check_pending(idx, vec.expected);
    rsp_ready = 1'b1;
    @(negedge clk);
    rsp_ready = 1'b0;
    check_idle($sformatf("vector %0d after transfer", idx));
  endtask

  initial begin
    void'($urandom(32'h0efc_6bc9));
    clk             = 1'b0;
    reset           = 1'b1;
    cmd_valid       = 1'b0;
    cmd_function_id = '0;
    cmd_inputs_0    = '0;
    cmd_inputs_1    = '0;
    rsp_ready       = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    check_idle("after reset");
    for (int i = 0; i < NUM_VECTORS; i++) begin
      run_vector(i);
    end
    $display("Simulation passed");
    $finish;
  end

  // Twenty cycles per vector on top of reset
  initial begin
    #((RESET_CYCLES + NUM_VECTORS * 20) * CLK_PERIOD);
    stop_with_error("Timeout: the DUT response did not arrive in time");
  end

endmodule

//--- hw/cfu_top.sv
// ********************
// CFU top level
// Decoder, four byte MAC lanes and the result unit
// behind a command/response handshake
// ********************
module cfu_top (
  input  logic              cmd_valid,
  output logic              cmd_ready,
  input  cfu_pkg::func_id_t cmd_function_id,
  input  cfu_pkg::word_t    cmd_inputs_0,
  input  cfu_pkg::word_t    cmd_inputs_1,
  output logic              rsp_valid,
  input  logic              rsp_ready,
  output cfu_pkg::word_t    rsp_outputs_0,
  input  logic              clk,
  input  logic              reset
);
  import cfu_pkg::*;

  logic                 accept;
  op_t                  op;
  lane_byte_t           lane_in [NUM_LANES];
  lane_byte_t           lane_filter [NUM_LANES];
  logic [NUM_LANES-1:0] lane_en;
  offset_t              offset;
  product_t             products [NUM_LANES];

  cmd_decoder u_cmd_decoder (
    .clk         (clk),
    .reset       (reset),
    .accept      (accept),
    .function_id (cmd_function_id),
    .inputs_0    (cmd_inputs_0),
    .inputs_1    (cmd_inputs_1),
    .op          (op),
    .lane_in     (lane_in),
    .lane_filter (lane_filter),
    .lane_en     (lane_en),
    .offset      (offset)
  );

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    mac_lane u_mac_lane (
      .in_byte     (lane_in[i]),
      .filter_byte (lane_filter[i]),
      .offset      (offset),
      .enable      (lane_en[i]),
      .product     (products[i])
    );
  end

  result_unit u_result_unit (
    .clk       (clk),
    .reset     (reset),
    .op        (op),
    .products  (products),
    .operand   (cmd_inputs_0),
    .cmd_valid (cmd_valid),
    .rsp_ready (rsp_ready),
    .cmd_ready (cmd_ready),
    .accept    (accept),
    .rsp_valid (rsp_valid),
    .rsp_data  (rsp_outputs_0)
  );

endmodule

//--- hw/result_unit.sv
// ********************
// CFU result unit
// Lane sum, accumulator, quantization registers
// and the response handshake
// ********************
module result_unit (
  input  logic                clk,
  input  logic                reset,
  input  cfu_pkg::op_t        op,
  input  cfu_pkg::product_t   products [cfu_pkg::NUM_LANES],
  input  cfu_pkg::word_t      operand,
  input  logic                cmd_valid,
  input  logic                rsp_ready,
  output logic                cmd_ready,
  output logic                accept,
  output logic                rsp_valid,
  output cfu_pkg::word_t      rsp_data
);
  import cfu_pkg::*;

  word_t  lane_sum;
  word_t  multiplier;
  shift_t shift;
  word_t  accumulator;
  word_t  quant_value;
  word_t  quant_result;
  word_t  next_data;
  logic   acc_write;

  // One command in flight at a time
  assign cmd_ready = ~rsp_valid;
  assign accept    = cmd_valid & cmd_ready;

  always_comb begin
    lane_sum = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      lane_sum = lane_sum
               + {{($bits(word_t) - $bits(product_t)){products[i][17]}}, products[i]};
    end
  end

  assign quant_value = (op == OP_ACC_QUANT) ? accumulator : operand;

  requantizer u_requantizer (
    .value      (quant_value),
    .multiplier (multiplier),
    .shift      (shift),
    .result     (quant_result)
  );

  always_comb begin
    acc_write = 1'b0;
    case (op)
      OP_DOT:       next_data = lane_sum;
      OP_QUANT:     next_data = quant_result;
      OP_ACC_CLEAR: begin
        next_data = '0;
        acc_write = 1'b1;
      end
      OP_ACC_DOT: begin
        next_data = accumulator + lane_sum;
        acc_write = 1'b1;
      end
      OP_ACC_READ:  next_data = accumulator;
      OP_ACC_QUANT: begin
        next_data = quant_result;
        acc_write = 1'b1;
      end
      OP_ACC_BIAS: begin
        next_data = accumulator + operand;
        acc_write = 1'b1;
      end
      // Set operations and unknown codes echo operand 0
      default:      next_data = operand;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rsp_valid   <= 1'b0;
      multiplier  <= '0;
      shift       <= '0;
      accumulator <= '0;
    end else if (accept) begin
      rsp_valid <= 1'b1;
      if (op == OP_SET_MULT) begin
        multiplier <= operand;
      end
      if (op == OP_SET_SHIFT) begin
        shift <= operand[7:0];
      end
      if (acc_write) begin
        accumulator <= next_data;
      end
    end else if (rsp_valid && rsp_ready) begin
      rsp_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rsp_data <= next_data;
    end
  end

endmodule

//--- hw/cmd_decoder.sv
// ********************
// CFU command decoder
// Maps function IDs to operations, splits operands into
// byte lanes and holds the input offset
// ********************
module cmd_decoder (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 accept,
  input  cfu_pkg::func_id_t    function_id,
  input  cfu_pkg::word_t       inputs_0,
  input  cfu_pkg::word_t       inputs_1,
  output cfu_pkg::op_t         op,
  output cfu_pkg::lane_byte_t  lane_in [cfu_pkg::NUM_LANES],
  output cfu_pkg::lane_byte_t  lane_filter [cfu_pkg::NUM_LANES],
  output logic [cfu_pkg::NUM_LANES-1:0] lane_en,
  output cfu_pkg::offset_t     offset
);
  import cfu_pkg::*;

  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       tail_dot;

  assign funct3 = function_id[2:0];
  assign funct7 = function_id[9:3];

  always_comb begin
    op       = OP_ECHO;
    tail_dot = 1'b0;
    case (funct3)
      GRP_DOT: begin
        case (funct7)
          F7_SET_OFFSET: op = OP_SET_OFFSET;
          F7_DOT:        op = OP_DOT;
          F7_TAIL_DOT: begin
            op       = OP_DOT;
            tail_dot = 1'b1;
          end
          default:       op = OP_ECHO;
        endcase
      end
      GRP_QUANT: begin
        case (funct7)
          F7_SET_MULT:  op = OP_SET_MULT;
          F7_SET_SHIFT: op = OP_SET_SHIFT;
          F7_QUANT:     op = OP_QUANT;
          default:      op = OP_ECHO;
        endcase
      end
      GRP_ACC: begin
        case (funct7)
          F7_ACC_CLEAR: op = OP_ACC_CLEAR;
          F7_ACC_DOT:   op = OP_ACC_DOT;
          F7_ACC_READ:  op = OP_ACC_READ;
          F7_ACC_QUANT: op = OP_ACC_QUANT;
          F7_ACC_BIAS:  op = OP_ACC_BIAS;
          default:      op = OP_ECHO;
        endcase
      end
      default: op = OP_ECHO;
    endcase
  end

  always_comb begin
    lane_en = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      lane_in[i]     = inputs_0[8*i +: 8];
      lane_filter[i] = inputs_1[8*i +: 8];
    end
    if (op == OP_DOT && tail_dot) begin
      // Tail count sits in the top byte of the filter word
      for (int i = 0; i < NUM_LANES - 1; i++) begin
        lane_en[i] = (inputs_1[31:24] > 8'(i));
      end
    end else if (op == OP_DOT || op == OP_ACC_DOT) begin
      lane_en = '1;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      offset <= '0;
    end else if (accept && op == OP_SET_OFFSET) begin
      offset <= {inputs_0[7], inputs_0[7:0]};
    end
  end

endmodule

//--- hw/requantizer.sv
// ********************
// Fixed-point requantizer
// Rounding multiply by a Q31 multiplier, then shift
// ********************
module requantizer (
  input  cfu_pkg::word_t  value,
  input  cfu_pkg::word_t  multiplier,
  input  cfu_pkg::shift_t shift,
  output cfu_pkg::word_t  result
);
  import cfu_pkg::*;

  logic signed [63:0] full_product;
  logic signed [63:0] rounded;
  logic signed [63:0] shifted;
  logic signed [8:0]  total_shift;
  logic        [8:0]  left_amount;

  assign full_product = $signed(value) * $signed(multiplier);

  // Range of 31 - shift needs a ninth bit
  assign total_shift = 9'sd31 - shift;
  assign left_amount = 9'(-total_shift);

  always_comb begin
    rounded = full_product;
    if (total_shift > 0) begin
      // Add half a step before the arithmetic shift
      rounded = full_product + (64'sd1 <<< (total_shift - 9'sd1));
      shifted = rounded >>> total_shift;
    end else begin
      shifted = full_product <<< left_amount;
    end
  end

  assign result = shifted[31:0];

endmodule

//--- hw/mac_lane.sv
// ********************
// Single byte MAC lane
// Adds the input offset, multiplies by the filter byte
// ********************
module mac_lane (
  input  cfu_pkg::lane_byte_t in_byte,
  input  cfu_pkg::lane_byte_t filter_byte,
  input  cfu_pkg::offset_t    offset,
  input  logic                enable,
  output cfu_pkg::product_t   product
);
  import cfu_pkg::*;

  offset_t  in_ext;
  offset_t  filter_ext;
  product_t raw_product;

  // Offset sum fits in 9 bits for byte inputs
  assign in_ext     = offset_t'({in_byte[7], in_byte}) + offset;
  assign filter_ext = offset_t'({filter_byte[7], filter_byte});

  assign raw_product = in_ext * filter_ext;

  // Disabled lanes contribute nothing to the sum
  assign product = enable ? raw_product : '0;

endmodule

//--- hw/cfu_pkg.sv
// ********************
// CFU shared definitions
// Widths, function codes and the decoded operation type
// ********************
package cfu_pkg;

  typedef logic        [31:0] word_t;
  typedef logic        [9:0]  func_id_t;
  typedef logic signed [7:0]  lane_byte_t;
  typedef logic signed [8:0]  offset_t;
  typedef logic signed [17:0] product_t;
  typedef logic signed [7:0]  shift_t;

  // Bytes per 32-bit word
  localparam int NUM_LANES = 4;

  // Group codes (funct3)
  localparam logic [2:0] GRP_DOT   = 3'd0;
  localparam logic [2:0] GRP_QUANT = 3'd1;
  localparam logic [2:0] GRP_ACC   = 3'd2;

  // Dot product group (funct7)
  localparam logic [6:0] F7_SET_OFFSET = 7'd0;
  localparam logic [6:0] F7_DOT        = 7'd1;
  localparam logic [6:0] F7_TAIL_DOT   = 7'd2;

  // Requantization group (funct7)
  localparam logic [6:0] F7_SET_MULT  = 7'd0;
  localparam logic [6:0] F7_SET_SHIFT = 7'd1;
  localparam logic [6:0] F7_QUANT     = 7'd2;

  // Accumulator group (funct7)
  localparam logic [6:0] F7_ACC_CLEAR = 7'd0;
  localparam logic [6:0] F7_ACC_DOT   = 7'd1;
  localparam logic [6:0] F7_ACC_READ  = 7'd2;
  localparam logic [6:0] F7_ACC_QUANT = 7'd3;
  localparam logic [6:0] F7_ACC_BIAS  = 7'd4;

  typedef enum logic [3:0] {
    OP_ECHO, OP_SET_OFFSET, OP_DOT, OP_SET_MULT, OP_SET_SHIFT, OP_QUANT,
    OP_ACC_CLEAR, OP_ACC_DOT, OP_ACC_READ, OP_ACC_QUANT, OP_ACC_BIAS
  } op_t;

endpackage
